// ==== design/if_pkg.sv ====
////////////////////////////////////////
// shared widths and selector encodings for the IF stage
// addresses and instructions are XLEN wide, word aligned only
////////////////////////////////////////

`default_nettype none

package if_pkg;

  ////////////////////////////////////////
  // widths and alignment
  ////////////////////////////////////////

  // address and instruction word width
  parameter int unsigned XLEN = 32;

  // byte step between two sequential instructions
  parameter int unsigned INSTR_BYTES = 4;

  // low bits forced to zero in boot address and trap base
  parameter int unsigned BOOT_ALIGN_W = 8;

  // interrupt number width used for vectoring
  parameter int unsigned IRQ_ID_W = 5;

  ////////////////////////////////////////
  // selector encodings
  ////////////////////////////////////////

  // redirect target select
  typedef enum logic [2:0] {
    PC_BOOT = 3'd0,
    PC_JUMP = 3'd1,
    PC_EXC  = 3'd2,
    PC_ERET = 3'd3,
    PC_DRET = 3'd4
  } pc_sel_e;

  // exception vector select
  // dbd is the debug halt entry, dbg_exc an exception taken in debug mode
  typedef enum logic [1:0] {
    EXC_PC_EXC     = 2'd0,
    EXC_PC_IRQ     = 2'd1,
    EXC_PC_DBD     = 2'd2,
    EXC_PC_DBG_EXC = 2'd3
  } exc_pc_sel_e;

endpackage

`default_nettype wire

// ==== design/pc_select.sv ====
////////////////////////////////////////
// redirect target and exception vector mux
// trap base and boot address drop their low 8 bits
////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module pc_select #(
  parameter logic [31:0] DmHaltAddr      = 32'h1A11_0800,
  parameter logic [31:0] DmExceptionAddr = 32'h1A11_0808
) (
  input  if_pkg::pc_sel_e                  pc_mux_i,
  input  if_pkg::exc_pc_sel_e              exc_pc_mux_i,
  input  wire logic [if_pkg::IRQ_ID_W-1:0] irq_id_i,
  input  wire logic [if_pkg::XLEN-1:0]     boot_addr_i,
  input  wire logic [if_pkg::XLEN-1:0]     branch_target_i,
  input  wire logic [if_pkg::XLEN-1:0]     csr_mepc_i,
  input  wire logic [if_pkg::XLEN-1:0]     csr_depc_i,
  input  wire logic [if_pkg::XLEN-1:0]     csr_mtvec_i,
  input  wire logic                        pc_set_i,
  output logic [if_pkg::XLEN-1:0]          redirect_addr_o,
  output logic                             csr_mtvec_init_o
);

  logic [if_pkg::XLEN-1:0] trap_base;
  logic [if_pkg::XLEN-1:0] boot_base;
  logic [if_pkg::XLEN-1:0] irq_offset;
  logic [if_pkg::XLEN-1:0] exc_pc;

  // aligned bases
  assign trap_base = {csr_mtvec_i[if_pkg::XLEN-1:if_pkg::BOOT_ALIGN_W],
                      {if_pkg::BOOT_ALIGN_W{1'b0}}};
  assign boot_base = {boot_addr_i[if_pkg::XLEN-1:if_pkg::BOOT_ALIGN_W],
                      {if_pkg::BOOT_ALIGN_W{1'b0}}};

  // one word per interrupt line in the vector table
  assign irq_offset = {{(if_pkg::XLEN - if_pkg::IRQ_ID_W - 2){1'b0}}, irq_id_i, 2'b00};

  ////////////////////////////////////////
  // exception vector
  ////////////////////////////////////////

  always_comb begin
    unique case (exc_pc_mux_i)
      if_pkg::EXC_PC_EXC:     exc_pc = trap_base;
      if_pkg::EXC_PC_IRQ:     exc_pc = trap_base + irq_offset;
      if_pkg::EXC_PC_DBD:     exc_pc = DmHaltAddr;
      if_pkg::EXC_PC_DBG_EXC: exc_pc = DmExceptionAddr;
      default:                exc_pc = trap_base;
    endcase
  end

  ////////////////////////////////////////
  // redirect target
  ////////////////////////////////////////

  always_comb begin
    unique case (pc_mux_i)
      if_pkg::PC_BOOT: redirect_addr_o = boot_base;
      if_pkg::PC_JUMP: redirect_addr_o = branch_target_i;
      if_pkg::PC_EXC:  redirect_addr_o = exc_pc;
      // return from trap
      if_pkg::PC_ERET: redirect_addr_o = csr_mepc_i;
      // return from debug mode
      if_pkg::PC_DRET: redirect_addr_o = csr_depc_i;
      default:         redirect_addr_o = boot_base;
    endcase
  end

  // mtvec takes the boot address on the boot redirect
  assign csr_mtvec_init_o = pc_set_i & (pc_mux_i == if_pkg::PC_BOOT);

endmodule

`default_nettype wire

// ==== design/if_ctrl.sv ====
////////////////////////////////////////
// fetch controller, one bus transaction open at a time
// a redirect never aborts an open handshake, its data is dropped
////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module if_ctrl (
  input  wire logic                    clk_i,
  input  wire logic                    rst_ni,
  input  wire logic                    req_i,
  input  wire logic                    pc_set_i,
  input  wire logic [if_pkg::XLEN-1:0] redirect_addr_i,
  input  wire logic                    buf_valid_i,
  input  wire logic                    buf_pop_i,
  input  wire logic                    instr_ack_i,
  input  wire logic [if_pkg::XLEN-1:0] instr_rdata_i,
  input  wire logic                    instr_err_i,
  output logic                         instr_req_o,
  output logic [if_pkg::XLEN-1:0]      instr_addr_o,
  output logic                         buf_load_o,
  output logic [if_pkg::XLEN-1:0]      buf_rdata_o,
  output logic [if_pkg::XLEN-1:0]      buf_addr_o,
  output logic                         buf_err_o,
  output logic                         flush_o,
  output logic                         busy_o
);

  // handshake states
  localparam logic [1:0] StIdle   = 2'd0;
  localparam logic [1:0] StReq    = 2'd1;
  localparam logic [1:0] StAckLow = 2'd2;

  logic [1:0]              state_q, state_d;
  logic [if_pkg::XLEN-1:0] fetch_pc_q, fetch_pc_d;
  logic [if_pkg::XLEN-1:0] addr_q, addr_d;
  logic                    discard_q, discard_d;
  logic                    space;
  logic                    start;
  logic [if_pkg::XLEN-1:0] next_addr;

  // buffer has room next cycle, a flush empties it
  assign space     = ~buf_valid_i | buf_pop_i | pc_set_i;
  assign start     = req_i & space;
  // a redirect this cycle wins over the stored fetch pc
  assign next_addr = pc_set_i ? redirect_addr_i : fetch_pc_q;

  // word accepted only if no redirect overtook it
  assign buf_load_o = (state_q == StReq) & instr_ack_i & ~discard_q & ~pc_set_i;

  ////////////////////////////////////////
  // four-phase handshake
  ////////////////////////////////////////

  always_comb begin
    state_d   = state_q;
    addr_d    = addr_q;
    discard_d = discard_q;
    unique case (state_q)
      StIdle: begin
        if (start) begin
          state_d = StReq;
          addr_d  = next_addr;
        end
      end
      StReq: begin
        // phase 2, req drops on the next cycle
        if (instr_ack_i) begin
          state_d   = StAckLow;
          discard_d = 1'b0;
        end else if (pc_set_i) begin
          discard_d = 1'b1;
        end
      end
      StAckLow: begin
        // phase 4 done, may chain straight into a new request
        if (!instr_ack_i) begin
          if (start) begin
            state_d = StReq;
            addr_d  = next_addr;
          end else begin
            state_d = StIdle;
          end
        end
      end
      default: state_d = StIdle;
    endcase
  end

  // fetch pc points at the word still to be accepted
  always_comb begin
    if (pc_set_i) begin
      fetch_pc_d = redirect_addr_i;
    end else if (buf_load_o) begin
      fetch_pc_d = fetch_pc_q + if_pkg::INSTR_BYTES;
    end else begin
      fetch_pc_d = fetch_pc_q;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q    <= StIdle;
      discard_q  <= 1'b0;
      fetch_pc_q <= '0;
      addr_q     <= '0;
    end else begin
      state_q    <= state_d;
      discard_q  <= discard_d;
      fetch_pc_q <= fetch_pc_d;
      addr_q     <= addr_d;
    end
  end

  // bus side
  assign instr_req_o  = (state_q == StReq);
  assign instr_addr_o = addr_q;
  // busy while a handshake has not fully returned to idle
  assign busy_o       = (state_q != StIdle);

  // word as returned, tagged with the address it was fetched from
  assign buf_rdata_o = instr_rdata_i;
  assign buf_addr_o  = addr_q;
  assign buf_err_o   = instr_err_i;
  assign flush_o     = pc_set_i;

endmodule

`default_nettype wire

// ==== design/fetch_buffer.sv ====
////////////////////////////////////////
// single entry fetch buffer
// load and pop may share a cycle, flush wins
////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module fetch_buffer (
  input  wire logic                    clk_i,
  input  wire logic                    rst_ni,
  input  wire logic                    buf_load_i,
  input  wire logic [if_pkg::XLEN-1:0] buf_rdata_i,
  input  wire logic [if_pkg::XLEN-1:0] buf_addr_i,
  input  wire logic                    buf_err_i,
  input  wire logic                    flush_i,
  input  wire logic                    buf_pop_i,
  output logic                         buf_valid_o,
  output logic [if_pkg::XLEN-1:0]      buf_rdata_o,
  output logic [if_pkg::XLEN-1:0]      buf_addr_o,
  output logic                         buf_err_o
);

  logic valid_q, valid_d;

  // occupancy
  always_comb begin
    if (flush_i) begin
      valid_d = 1'b0;
    end else if (buf_load_i) begin
      // also covers load together with pop
      valid_d = 1'b1;
    end else if (buf_pop_i) begin
      valid_d = 1'b0;
    end else begin
      valid_d = valid_q;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= valid_d;
    end
  end

  // entry payload
  always_ff @(posedge clk_i) begin
    if (buf_load_i) begin
      buf_rdata_o <= buf_rdata_i;
      buf_addr_o  <= buf_addr_i;
      buf_err_o   <= buf_err_i;
    end
  end

  assign buf_valid_o = valid_q;

endmodule

`default_nettype wire

// ==== design/if_id_reg.sv ====
////////////////////////////////////////
// IF-ID pipeline register
// valid holds until cleared or flushed
////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module if_id_reg (
  input  wire logic                    clk_i,
  input  wire logic                    rst_ni,
  input  wire logic                    buf_valid_i,
  input  wire logic [if_pkg::XLEN-1:0] buf_rdata_i,
  input  wire logic [if_pkg::XLEN-1:0] buf_addr_i,
  input  wire logic                    buf_err_i,
  input  wire logic                    id_in_ready_i,
  input  wire logic                    instr_valid_clear_i,
  input  wire logic                    flush_i,
  output logic                         buf_pop_o,
  output logic                         instr_valid_id_o,
  output logic                         instr_new_id_o,
  output logic [if_pkg::XLEN-1:0]      instr_rdata_id_o,
  output logic                         instr_fetch_err_o,
  output logic [if_pkg::XLEN-1:0]      pc_id_o,
  output logic [if_pkg::XLEN-1:0]      pc_if_o
);

  logic valid_d;
  logic new_d;

  // ID takes the buffered word
  assign buf_pop_o = buf_valid_i & id_in_ready_i;

  // a word copied under a flush is stale, so it enters invalid
  // and does not count as new
  assign new_d   = buf_pop_o & ~flush_i;
  assign valid_d = new_d | (instr_valid_id_o & ~instr_valid_clear_i & ~flush_i);

  ////////////////////////////////////////
  // flags
  ////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      instr_valid_id_o <= 1'b0;
      instr_new_id_o   <= 1'b0;
    end else begin
      instr_valid_id_o <= valid_d;
      // one cycle pulse per accepted word
      instr_new_id_o   <= new_d;
    end
  end

  // ID payload, frozen while ID stalls
  always_ff @(posedge clk_i) begin
    if (buf_pop_o) begin
      instr_rdata_id_o  <= buf_rdata_i;
      instr_fetch_err_o <= buf_err_i;
      pc_id_o           <= buf_addr_i;
    end
  end

  // address of the word waiting in IF
  assign pc_if_o = buf_addr_i;

endmodule

`default_nettype wire

// ==== design/if_stage.sv ====
////////////////////////////////////////
// instruction fetch stage, 32-bit words only
// bus is a four-phase req/ack handshake
// debug addresses must be word aligned
////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module if_stage #(
  parameter logic [31:0] DmHaltAddr      = 32'h1A11_0800,
  parameter logic [31:0] DmExceptionAddr = 32'h1A11_0808
) (
  input  wire logic                        clk_i,
  input  wire logic                        rst_ni,
  // control from the core
  input  wire logic                        req_i,
  input  wire logic                        pc_set_i,
  input  if_pkg::pc_sel_e                  pc_mux_i,
  input  if_pkg::exc_pc_sel_e              exc_pc_mux_i,
  input  wire logic [if_pkg::IRQ_ID_W-1:0] irq_id_i,
  input  wire logic [if_pkg::XLEN-1:0]     boot_addr_i,
  input  wire logic [if_pkg::XLEN-1:0]     branch_target_i,
  input  wire logic [if_pkg::XLEN-1:0]     csr_mepc_i,
  input  wire logic [if_pkg::XLEN-1:0]     csr_depc_i,
  input  wire logic [if_pkg::XLEN-1:0]     csr_mtvec_i,
  input  wire logic                        id_in_ready_i,
  input  wire logic                        instr_valid_clear_i,
  // instruction bus
  output logic                             instr_req_o,
  output logic [if_pkg::XLEN-1:0]          instr_addr_o,
  input  wire logic                        instr_ack_i,
  input  wire logic [if_pkg::XLEN-1:0]     instr_rdata_i,
  input  wire logic                        instr_err_i,
  // to the ID stage
  output logic                             instr_valid_id_o,
  output logic                             instr_new_id_o,
  output logic [if_pkg::XLEN-1:0]          instr_rdata_id_o,
  output logic                             instr_fetch_err_o,
  output logic [if_pkg::XLEN-1:0]          pc_id_o,
  output logic [if_pkg::XLEN-1:0]          pc_if_o,
  output logic                             csr_mtvec_init_o,
  output logic                             if_busy_o
);

  // redirect target into the controller
  logic [if_pkg::XLEN-1:0] redirect_addr;

  // controller to buffer, word as seen on the bus
  logic                    buf_load;
  logic [if_pkg::XLEN-1:0] load_rdata;
  logic [if_pkg::XLEN-1:0] load_addr;
  logic                    load_err;
  logic                    flush;

  // buffer entry towards the ID register
  logic                    buf_valid;
  logic [if_pkg::XLEN-1:0] buf_rdata;
  logic [if_pkg::XLEN-1:0] buf_addr;
  logic                    buf_err;
  logic                    buf_pop;

  ////////////////////////////////////////
  // target selection
  ////////////////////////////////////////

  pc_select #(
    .DmHaltAddr      (DmHaltAddr),
    .DmExceptionAddr (DmExceptionAddr)
  ) u_pc_select (
    .pc_mux_i         (pc_mux_i),
    .exc_pc_mux_i     (exc_pc_mux_i),
    .irq_id_i         (irq_id_i),
    .boot_addr_i      (boot_addr_i),
    .branch_target_i  (branch_target_i),
    .csr_mepc_i       (csr_mepc_i),
    .csr_depc_i       (csr_depc_i),
    .csr_mtvec_i      (csr_mtvec_i),
    .pc_set_i         (pc_set_i),
    .redirect_addr_o  (redirect_addr),
    .csr_mtvec_init_o (csr_mtvec_init_o)
  );

  ////////////////////////////////////////
  // fetch control and bus
  ////////////////////////////////////////

  if_ctrl u_if_ctrl (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .req_i           (req_i),
    .pc_set_i        (pc_set_i),
    .redirect_addr_i (redirect_addr),
    .buf_valid_i     (buf_valid),
    .buf_pop_i       (buf_pop),
    .instr_ack_i     (instr_ack_i),
    .instr_rdata_i   (instr_rdata_i),
    .instr_err_i     (instr_err_i),
    .instr_req_o     (instr_req_o),
    .instr_addr_o    (instr_addr_o),
    .buf_load_o      (buf_load),
    .buf_rdata_o     (load_rdata),
    .buf_addr_o      (load_addr),
    .buf_err_o       (load_err),
    .flush_o         (flush),
    .busy_o          (if_busy_o)
  );

  // one word between bus and ID
  fetch_buffer u_fetch_buffer (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .buf_load_i  (buf_load),
    .buf_rdata_i (load_rdata),
    .buf_addr_i  (load_addr),
    .buf_err_i   (load_err),
    .flush_i     (flush),
    .buf_pop_i   (buf_pop),
    .buf_valid_o (buf_valid),
    .buf_rdata_o (buf_rdata),
    .buf_addr_o  (buf_addr),
    .buf_err_o   (buf_err)
  );

  if_id_reg u_if_id_reg (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .buf_valid_i         (buf_valid),
    .buf_rdata_i         (buf_rdata),
    .buf_addr_i          (buf_addr),
    .buf_err_i           (buf_err),
    .id_in_ready_i       (id_in_ready_i),
    .instr_valid_clear_i (instr_valid_clear_i),
    .flush_i             (flush),
    .buf_pop_o           (buf_pop),
    .instr_valid_id_o    (instr_valid_id_o),
    .instr_new_id_o      (instr_new_id_o),
    .instr_rdata_id_o    (instr_rdata_id_o),
    .instr_fetch_err_o   (instr_fetch_err_o),
    .pc_id_o             (pc_id_o),
    .pc_if_o             (pc_if_o)
  );

endmodule

`default_nettype wire

// ==== tb/if_stage_chk.sv ====
////////////////////////////////////////
// bus handshake and selector assertions
// bound into every if_stage instance
////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module if_stage_chk (
  input wire logic                    clk_i,
  input wire logic                    rst_ni,
  input wire logic                    instr_req_o,
  input wire logic [if_pkg::XLEN-1:0] instr_addr_o,
  input wire logic                    instr_ack_i,
  input wire logic                    pc_set_i,
  input wire logic [2:0]              pc_mux_i,
  input wire logic [1:0]              exc_pc_mux_i
);

  // phase 1 to 3, address held
  addr_stable_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
    instr_req_o |=> (!instr_req_o || $stable(instr_addr_o)))
    else $error("instruction address changed while req was high");

  addr_aligned_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
    instr_req_o |-> (instr_addr_o[1:0] == 2'b00))
    else $error("instruction address is not word aligned");

  // new req only once ack was seen low at the edge that raised it
  req_after_ack_low_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
    $rose(instr_req_o) |-> !$past(instr_ack_i))
    else $error("req rose while ack was still high");

  sel_known_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
    pc_set_i |-> !$isunknown({pc_mux_i, exc_pc_mux_i}))
    else $error("redirect selectors unknown during pc_set_i");

endmodule

bind if_stage if_stage_chk u_if_stage_chk (
  .clk_i        (clk_i),
  .rst_ni       (rst_ni),
  .instr_req_o  (instr_req_o),
  .instr_addr_o (instr_addr_o),
  .instr_ack_i  (instr_ack_i),
  .pc_set_i     (pc_set_i),
  .pc_mux_i     (pc_mux_i),
  .exc_pc_mux_i (exc_pc_mux_i)
);

`default_nettype wire

// ==== tb/tb_if_stage.sv ====
////////////////////////////////////////
// testbench for the IF stage
// memory answers with random delays from a 16-bit LFSR
// words are addr ^ pattern, one fixed error window
////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module tb_if_stage;

  localparam int          CLK_PERIOD      = 100;
  localparam logic [31:0] DM_HALT_ADDR    = 32'h0000_5000;
  localparam logic [31:0] DM_EXC_ADDR     = 32'h0000_5800;
  localparam logic [31:0] WORD_PATTERN    = 32'hA5C3_0F96;
  localparam logic [31:0] ERR_LO          = 32'h0000_3000;
  localparam logic [31:0] ERR_HI          = 32'h0000_3010;
  localparam logic [31:0] ALIGN_MASK      = 32'hFFFF_FF00;
  // words fetched per test section
  localparam int          N_BOOT          = 12;
  localparam int          N_RUN           = 8;
  localparam int          N_STALL         = 24;
  localparam int          TOTAL_INSTRS    = N_BOOT + 10 * N_RUN + N_STALL;
  // req, 3 idle, ack, 2 to drop ack, chain, plus margin
  localparam int          WORST_HS_CYCLES = 10;
  // factor 4 leaves room for ID stalls
  localparam int          WATCHDOG_CYCLES = TOTAL_INSTRS * WORST_HS_CYCLES * 4 + 200;

  logic                    clk_i = 1'b0;
  logic                    rst_ni;
  logic                    req_i;
  logic                    pc_set_i;
  if_pkg::pc_sel_e         pc_mux_i;
  if_pkg::exc_pc_sel_e     exc_pc_mux_i;
  logic [4:0]              irq_id_i;
  logic [31:0]             boot_addr_i;
  logic [31:0]             branch_target_i;
  logic [31:0]             csr_mepc_i;
  logic [31:0]             csr_depc_i;
  logic [31:0]             csr_mtvec_i;
  logic                    id_in_ready_i;
  logic                    instr_valid_clear_i;
  logic                    instr_req_o;
  logic [31:0]             instr_addr_o;
  logic                    instr_ack_i;
  logic [31:0]             instr_rdata_i;
  logic                    instr_err_i;
  logic                    instr_valid_id_o;
  logic                    instr_new_id_o;
  logic [31:0]             instr_rdata_id_o;
  logic                    instr_fetch_err_o;
  logic [31:0]             pc_id_o;
  logic [31:0]             pc_if_o;
  logic                    csr_mtvec_init_o;
  logic                    if_busy_o;

  logic [15:0] lfsr_q = 16'd82;
  logic [31:0] exp_pc = '0;
  int          new_count = 0;
  int          error_count = 0;
  int          check_count = 0;
  logic        stall_mode = 1'b0;
  logic        valid_prev = 1'b0;
  logic        clear_prev = 1'b0;
  logic        set_prev = 1'b0;
  logic [31:0] pc_if_prev = '0;
  // high only while a boot redirect is being driven
  logic        exp_mtvec_init = 1'b0;

  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  if_stage #(
    .DmHaltAddr      (DM_HALT_ADDR),
    .DmExceptionAddr (DM_EXC_ADDR)
  ) u_if_stage (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .req_i               (req_i),
    .pc_set_i            (pc_set_i),
    .pc_mux_i            (pc_mux_i),
    .exc_pc_mux_i        (exc_pc_mux_i),
    .irq_id_i            (irq_id_i),
    .boot_addr_i         (boot_addr_i),
    .branch_target_i     (branch_target_i),
    .csr_mepc_i          (csr_mepc_i),
    .csr_depc_i          (csr_depc_i),
    .csr_mtvec_i         (csr_mtvec_i),
    .id_in_ready_i       (id_in_ready_i),
    .instr_valid_clear_i (instr_valid_clear_i),
    .instr_req_o         (instr_req_o),
    .instr_addr_o        (instr_addr_o),
    .instr_ack_i         (instr_ack_i),
    .instr_rdata_i       (instr_rdata_i),
    .instr_err_i         (instr_err_i),
    .instr_valid_id_o    (instr_valid_id_o),
    .instr_new_id_o      (instr_new_id_o),
    .instr_rdata_id_o    (instr_rdata_id_o),
    .instr_fetch_err_o   (instr_fetch_err_o),
    .pc_id_o             (pc_id_o),
    .pc_if_o             (pc_if_o),
    .csr_mtvec_init_o    (csr_mtvec_init_o),
    .if_busy_o           (if_busy_o)
  );

  ////////////////////////////////////////
  // reference model
  ////////////////////////////////////////

  function automatic logic [31:0] mem_word(input logic [31:0] addr);
    return addr ^ WORD_PATTERN;
  endfunction

  function automatic logic in_err_window(input logic [31:0] addr);
    return (addr >= ERR_LO) && (addr < ERR_HI);
  endfunction

  // where the next word must come from after a redirect
  function automatic logic [31:0] expected_target(input if_pkg::pc_sel_e sel,
                                                  input if_pkg::exc_pc_sel_e exc_sel);
    logic [31:0] base;
    base = csr_mtvec_i & ALIGN_MASK;
    case (sel)
      if_pkg::PC_BOOT: return boot_addr_i & ALIGN_MASK;
      if_pkg::PC_JUMP: return branch_target_i;
      if_pkg::PC_ERET: return csr_mepc_i;
      if_pkg::PC_DRET: return csr_depc_i;
      default: begin
        case (exc_sel)
          if_pkg::EXC_PC_IRQ: return base + 32'(irq_id_i) * 4;
          if_pkg::EXC_PC_DBD: return DM_HALT_ADDR;
          if_pkg::EXC_PC_DBG_EXC: return DM_EXC_ADDR;
          default: return base;
        endcase
      end
    endcase
  endfunction

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_next(input logic [15:0] state);
    logic fb;
    fb = state[15] ^ state[13] ^ state[12] ^ state[10];
    return {state[14:0], fb};
  endfunction

  task automatic draw_bits(input int n, output int unsigned value);
    value = 0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_next(lfsr_q);
      value  = (value << 1) | lfsr_q[0];
    end
  endtask

  task automatic check_value(input string what, input logic [31:0] got,
                             input logic [31:0] exp);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("ERR @%0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  ////////////////////////////////////////
  // bus memory, four-phase slave
  ////////////////////////////////////////

  initial begin : memory_model
    int unsigned delay;
    instr_ack_i   = 1'b0;
    instr_rdata_i = '0;
    instr_err_i   = 1'b0;
    forever begin
      @(posedge clk_i);
      #10;
      if (instr_req_o && !instr_ack_i) begin
        // 0 to 3 idle cycles before ack
        draw_bits(2, delay);
        repeat (delay) begin
          @(posedge clk_i);
          #10;
        end
        instr_ack_i   = 1'b1;
        instr_rdata_i = mem_word(instr_addr_o);
        instr_err_i   = in_err_window(instr_addr_o);
        // wait for req to fall
        do begin
          @(posedge clk_i);
          #10;
        end while (instr_req_o);
        draw_bits(2, delay);
        repeat (delay % 3) begin
          @(posedge clk_i);
          #10;
        end
        instr_ack_i = 1'b0;
      end
    end
  end

  // ID side, random stalls and clears drawn at the falling edge
  initial begin : id_side
    int unsigned ready_draw;
    int unsigned clear_draw;
    forever begin
      @(negedge clk_i);
      ready_draw = 1;
      clear_draw = 0;
      if (stall_mode) begin
        draw_bits(2, ready_draw);
        draw_bits(1, clear_draw);
      end
      @(posedge clk_i);
      #10;
      id_in_ready_i       = (ready_draw != 0);
      instr_valid_clear_i = clear_draw[0];
    end
  end

  ////////////////////////////////////////
  // comparison
  ////////////////////////////////////////

  always @(negedge clk_i) begin : compare_proc
    if (rst_ni) begin
      check_value("csr_mtvec_init_o", csr_mtvec_init_o, exp_mtvec_init);
      // valid may only drop one cycle after a clear or a redirect
      if (valid_prev && !instr_valid_id_o && !clear_prev && !set_prev) begin
        check_value("instr_valid_id_o held", instr_valid_id_o, 1'b1);
      end
      if (instr_new_id_o) begin
        // the word now in ID sat in the buffer one cycle earlier
        check_value("pc_if_o before pop", pc_if_prev, exp_pc);
        check_value("pc_id_o", pc_id_o, exp_pc);
        check_value("instr_rdata_id_o", instr_rdata_id_o, mem_word(exp_pc));
        check_value("instr_fetch_err_o", instr_fetch_err_o, in_err_window(exp_pc));
        check_value("instr_valid_id_o on new", instr_valid_id_o, 1'b1);
        exp_pc = exp_pc + 4;
        new_count++;
      end
      // a redirect counts after the word shown in its own cycle
      if (pc_set_i) begin
        exp_pc = expected_target(pc_mux_i, exc_pc_mux_i);
      end
      valid_prev = instr_valid_id_o;
      clear_prev = instr_valid_clear_i;
      set_prev   = pc_set_i;
      pc_if_prev = pc_if_o;
    end
  end

  ////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////

  task automatic redirect(input if_pkg::pc_sel_e sel, input if_pkg::exc_pc_sel_e exc_sel,
                          input logic [31:0] jump_addr);
    @(posedge clk_i);
    #10;
    branch_target_i = jump_addr;
    pc_mux_i        = sel;
    exc_pc_mux_i    = exc_sel;
    pc_set_i        = 1'b1;
    exp_mtvec_init  = (sel == if_pkg::PC_BOOT);
    @(posedge clk_i);
    #10;
    pc_set_i       = 1'b0;
    exp_mtvec_init = 1'b0;
  endtask

  task automatic wait_instrs(input int n);
    int target;
    int cycles;
    target = new_count + n;
    cycles = 0;
    while (new_count < target && cycles < n * WORST_HS_CYCLES * 4) begin
      @(posedge clk_i);
      cycles++;
    end
    if (new_count < target) begin
      error_count++;
      $display("timed out waiting for %0d instructions, got %0d", n, n - (target - new_count));
    end
  endtask

  initial begin : watchdog
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("watchdog expired, the run did not complete in time");
    $display("SIMULATION FAILED");
    $finish;
  end

  initial begin : stimulus
    int cycles;
    rst_ni              = 1'b0;
    req_i               = 1'b0;
    pc_set_i            = 1'b0;
    pc_mux_i            = if_pkg::PC_BOOT;
    exc_pc_mux_i        = if_pkg::EXC_PC_EXC;
    irq_id_i            = 5'd9;
    boot_addr_i         = 32'h0000_1234;
    branch_target_i     = '0;
    csr_mepc_i          = 32'h0000_2400;
    csr_depc_i          = 32'h0000_2800;
    csr_mtvec_i         = 32'h0000_3081;
    id_in_ready_i       = 1'b1;
    instr_valid_clear_i = 1'b0;
    repeat (2) @(posedge clk_i);
    #10;
    rst_ni = 1'b1;
    @(negedge clk_i);
    check_value("instr_req_o after reset", instr_req_o, 1'b0);
    check_value("instr_valid_id_o after reset", instr_valid_id_o, 1'b0);
    check_value("instr_new_id_o after reset", instr_new_id_o, 1'b0);
    check_value("csr_mtvec_init_o after reset", csr_mtvec_init_o, 1'b0);
    check_value("if_busy_o after reset", if_busy_o, 1'b0);
    @(posedge clk_i);
    #10;
    req_i = 1'b1;
    // boot, then sequential run
    redirect(if_pkg::PC_BOOT, if_pkg::EXC_PC_EXC, '0);
    wait_instrs(N_BOOT);
    // jump, mret, dret
    redirect(if_pkg::PC_JUMP, if_pkg::EXC_PC_EXC, 32'h0000_2000);
    wait_instrs(N_RUN);
    redirect(if_pkg::PC_ERET, if_pkg::EXC_PC_EXC, '0);
    wait_instrs(N_RUN);
    redirect(if_pkg::PC_DRET, if_pkg::EXC_PC_EXC, '0);
    wait_instrs(N_RUN);
    // exception vectors, the trap base sits in the error window
    redirect(if_pkg::PC_EXC, if_pkg::EXC_PC_EXC, '0);
    wait_instrs(N_RUN);
    redirect(if_pkg::PC_EXC, if_pkg::EXC_PC_IRQ, '0);
    wait_instrs(N_RUN);
    redirect(if_pkg::PC_EXC, if_pkg::EXC_PC_DBD, '0);
    wait_instrs(N_RUN);
    redirect(if_pkg::PC_EXC, if_pkg::EXC_PC_DBG_EXC, '0);
    wait_instrs(N_RUN);
    // fetch gating, open handshake finishes then bus stays quiet
    @(posedge clk_i);
    #10;
    req_i  = 1'b0;
    cycles = 0;
    do begin
      @(negedge clk_i);
      cycles++;
    end while (if_busy_o && cycles < WORST_HS_CYCLES);
    check_value("if_busy_o with fetch gated", if_busy_o, 1'b0);
    repeat (4) begin
      @(negedge clk_i);
      check_value("instr_req_o with fetch gated", instr_req_o, 1'b0);
    end
    @(posedge clk_i);
    #10;
    req_i = 1'b1;
    wait_instrs(N_RUN);
    // run across the error window edges
    redirect(if_pkg::PC_JUMP, if_pkg::EXC_PC_EXC, 32'h0000_2FF8);
    wait_instrs(N_RUN);
    // random back-pressure, with a redirect in the middle
    stall_mode = 1'b1;
    redirect(if_pkg::PC_JUMP, if_pkg::EXC_PC_EXC, 32'h0000_6000);
    wait_instrs(N_STALL);
    redirect(if_pkg::PC_JUMP, if_pkg::EXC_PC_EXC, 32'h0000_6800);
    wait_instrs(N_RUN);
    stall_mode = 1'b0;
    repeat (4) @(posedge clk_i);
    $display("checks %0d, errors %0d, instructions %0d", check_count, error_count, new_count);
    if (error_count == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== src.f ====
design/if_pkg.sv
design/pc_select.sv
design/if_ctrl.sv
design/fetch_buffer.sv
design/if_id_reg.sv
design/if_stage.sv
tb/if_stage_chk.sv
tb/tb_if_stage.sv

// ==== Bender.yml ====
package:
  name: if_stage

sources:
  # package first, then leaf modules, then the top level
  - files:
      - design/if_pkg.sv
      - design/pc_select.sv
      - design/if_ctrl.sv
      - design/fetch_buffer.sv
      - design/if_id_reg.sv
      - design/if_stage.sv
  - target: simulation
    files:
      - tb/if_stage_chk.sv
      - tb/tb_if_stage.sv
